// File: design/dcache_array.sv
// direct-mapped cache storage
`default_nettype none
`include "dcache_defs.svh"

module dcache_array (
  input  logic                  clock,
  input  logic                  reset,
  input  logic [`ADDR_BITS-1:0] lookup_addr,
  output dcache_pkg::array_rd_t lookup,
  input  dcache_pkg::array_wr_t store_wr,
  input  dcache_pkg::array_wr_t fill_wr
);

  localparam int IDX_LO = `DCACHE_OFS_BITS;
  localparam int TAG_LO = `DCACHE_OFS_BITS + `DCACHE_IDX_BITS;

  logic [`DCACHE_LINES-1:0]    valid;
  logic [`DCACHE_TAG_BITS-1:0] tags  [`DCACHE_LINES];
  logic [`DATA_BITS-1:0]       words [`DCACHE_LINES];

  logic [`DCACHE_IDX_BITS-1:0] rd_idx;
  logic [`DCACHE_TAG_BITS-1:0] rd_tag;

  assign rd_idx = lookup_addr[IDX_LO +: `DCACHE_IDX_BITS];
  assign rd_tag = lookup_addr[TAG_LO +: `DCACHE_TAG_BITS];

  // combinational lookup
  assign lookup.hit  = valid[rd_idx] && (tags[rd_idx] == rd_tag);
  assign lookup.data = words[rd_idx];

  always_ff @(posedge clock)
  begin
    if (reset)
    begin
      valid <= '0;   // whole cache invalid
    end
    else
    begin
      if (fill_wr.en)
        valid[fill_wr.idx] <= 1'b1;
      if (store_wr.en)
        valid[store_wr.idx] <= 1'b1;
    end
  end

  // fill first, store last so a store wins on the same line
  always_ff @(posedge clock)
  begin
    if (fill_wr.en)
    begin
      tags[fill_wr.idx]  <= fill_wr.tag;
      words[fill_wr.idx] <= fill_wr.data;
    end
    if (store_wr.en)
    begin
      tags[store_wr.idx]  <= store_wr.tag;
      words[store_wr.idx] <= store_wr.data;
    end
  end

endmodule

`default_nettype wire

// File: design/dcache_ctrl.sv
// data cache controller
`default_nettype none
`include "dcache_defs.svh"

module dcache_ctrl (
  input  logic                  clock,
  input  logic                  reset,
  input  dcache_pkg::lsq_req_t  lsq_req,
  output logic                  req_ready,
  output dcache_pkg::cdb_t      cdb,
  input  logic                  halt,
  output logic                  halted,
  output logic [`ADDR_BITS-1:0] lookup_addr,
  input  dcache_pkg::array_rd_t lookup,
  output dcache_pkg::array_wr_t store_wr,
  output dcache_pkg::array_wr_t fill_wr,
  output dcache_pkg::mem_req_t  mem_req,
  input  dcache_pkg::mem_rsp_t  mem_rsp
);

  localparam int PTR_BITS = $clog2(`CMDQ_DEPTH);
  localparam int SLOTS = 1 << `XACT_NUM_BITS;
  localparam int IDX_LO = `DCACHE_OFS_BITS;
  localparam int TAG_LO = `DCACHE_OFS_BITS + `DCACHE_IDX_BITS;
  localparam logic [PTR_BITS:0] FULL = (PTR_BITS + 1)'(`CMDQ_DEPTH);
  localparam logic [PTR_BITS-1:0] LAST = PTR_BITS'(`CMDQ_DEPTH - 1);

  // command queue entry, loads misses and all stores
  typedef struct packed {
    dcache_pkg::mem_cmd_e  cmd;
    logic [`ADDR_BITS-1:0] addr;
    logic [`DATA_BITS-1:0] data;
    dcache_pkg::dest_t     dest;
    logic                  no_fill;   // a younger store hit this index
  } cmdq_entry_t;

  // tag table slot, keyed by transaction number
  typedef struct packed {
    logic [`DCACHE_IDX_BITS-1:0] idx;
    logic [`DCACHE_TAG_BITS-1:0] tag;
    dcache_pkg::dest_t           dest;
    logic                        no_fill;
  } slot_t;

  cmdq_entry_t         cmdq [`CMDQ_DEPTH];
  logic [PTR_BITS-1:0] head;
  logic [PTR_BITS-1:0] tail;
  logic [PTR_BITS-1:0] head_next;
  logic [PTR_BITS-1:0] tail_next;
  logic [PTR_BITS:0]   count;

  slot_t            slots [SLOTS];
  logic [SLOTS-1:0] occupied;
  logic             halt_seen;

  logic                        take;
  logic                        store_in;
  logic                        hit_load;
  logic                        enq;
  logic                        deq;
  logic                        ret;
  logic                        head_marked;
  logic [`DCACHE_IDX_BITS-1:0] req_idx;
  logic [`DCACHE_TAG_BITS-1:0] req_tag;
  cmdq_entry_t                 head_entry;
  slot_t                       ret_slot;

  assign req_idx     = lsq_req.addr[IDX_LO +: `DCACHE_IDX_BITS];
  assign req_tag     = lsq_req.addr[TAG_LO +: `DCACHE_TAG_BITS];
  assign lookup_addr = lsq_req.addr;

  // a fill owns the cdb this cycle, so hold the core off
  assign req_ready = (count != FULL) && (mem_rsp.tag == '0);

  assign take     = (lsq_req.load || lsq_req.store) && req_ready;
  assign store_in = take && lsq_req.store;
  assign hit_load = take && !lsq_req.store && lookup.hit;
  assign enq      = store_in || (take && !lookup.hit);

  assign head_next = (head == LAST) ? '0 : head + 1'b1;
  assign tail_next = (tail == LAST) ? '0 : tail + 1'b1;

  assign head_entry   = cmdq[head];
  assign mem_req.cmd  = (count == '0) ? dcache_pkg::MEM_NONE : head_entry.cmd;
  assign mem_req.addr = head_entry.addr;
  assign mem_req.data = head_entry.data;

  assign deq = (mem_req.cmd != dcache_pkg::MEM_NONE) && (mem_rsp.response != '0);
  assign ret = (mem_rsp.tag != '0) && occupied[mem_rsp.tag];
  assign ret_slot = slots[mem_rsp.tag];

  // a store entering now also counts against the head moving out
  assign head_marked = head_entry.no_fill ||
                       (store_in && head_entry.addr[IDX_LO +: `DCACHE_IDX_BITS] == req_idx);

  // write-through, only when the line is present
  assign store_wr.en   = store_in && lookup.hit;
  assign store_wr.idx  = req_idx;
  assign store_wr.tag  = req_tag;
  assign store_wr.data = lsq_req.st_data;

  assign fill_wr.en   = ret && !ret_slot.no_fill;
  assign fill_wr.idx  = ret_slot.idx;
  assign fill_wr.tag  = ret_slot.tag;
  assign fill_wr.data = mem_rsp.data;

  always_comb
  begin
    cdb = '0;
    if (ret)
    begin
      cdb.valid = 1'b1;
      cdb.dest  = ret_slot.dest;
      cdb.data  = mem_rsp.data;
    end
    else if (hit_load)
    begin
      cdb.valid = 1'b1;   // same-cycle hit
      cdb.dest  = lsq_req.dest;
      cdb.data  = lookup.data;
    end
  end

  always_ff @(posedge clock)
  begin
    if (reset)
    begin
      head  <= '0;
      tail  <= '0;
      count <= '0;
    end
    else
    begin
      if (enq)
        tail <= tail_next;
      if (deq)
        head <= head_next;
      unique case ({enq, deq})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  always_ff @(posedge clock)
  begin
    for (int i = 0; i < `CMDQ_DEPTH; i++)
    begin
      if (store_in && cmdq[i].addr[IDX_LO +: `DCACHE_IDX_BITS] == req_idx)
        cmdq[i].no_fill <= 1'b1;
    end
    if (enq)
    begin
      cmdq[tail].cmd     <= lsq_req.store ? dcache_pkg::MEM_STORE : dcache_pkg::MEM_LOAD;
      cmdq[tail].addr    <= lsq_req.addr;
      cmdq[tail].data    <= lsq_req.st_data;
      cmdq[tail].dest    <= lsq_req.dest;
      cmdq[tail].no_fill <= 1'b0;
    end
  end

  always_ff @(posedge clock)
  begin
    if (reset)
    begin
      occupied  <= '0;
      halt_seen <= 1'b0;
      halted    <= 1'b0;
    end
    else
    begin
      if (ret)
        occupied[mem_rsp.tag] <= 1'b0;
      if (deq && head_entry.cmd == dcache_pkg::MEM_LOAD)
        occupied[mem_rsp.response] <= 1'b1;   // stores take no slot
      halt_seen <= halt_seen || halt;
      if (halt_seen && count == '0 && occupied == '0)
        halted <= 1'b1;
    end
  end

  always_ff @(posedge clock)
  begin
    for (int i = 0; i < SLOTS; i++)
    begin
      if (store_in && occupied[i] && slots[i].idx == req_idx)
        slots[i].no_fill <= 1'b1;
    end
    if (deq && head_entry.cmd == dcache_pkg::MEM_LOAD)
    begin
      slots[mem_rsp.response].idx     <= head_entry.addr[IDX_LO +: `DCACHE_IDX_BITS];
      slots[mem_rsp.response].tag     <= head_entry.addr[TAG_LO +: `DCACHE_TAG_BITS];
      slots[mem_rsp.response].dest    <= head_entry.dest;
      slots[mem_rsp.response].no_fill <= head_marked;
    end
  end

endmodule

`default_nettype wire

// File: design/dcache_defs.svh
// data cache sizing
`ifndef DCACHE_DEFS_SVH
`define DCACHE_DEFS_SVH

// cache geometry, one 64-bit word per line
`define DCACHE_IDX_BITS 5
`define DCACHE_LINES (1 << `DCACHE_IDX_BITS)
`define DCACHE_OFS_BITS 3   // byte offset inside a word

// byte address and the tag left above index and offset
`define ADDR_BITS 32
`define DCACHE_TAG_BITS (`ADDR_BITS - `DCACHE_IDX_BITS - `DCACHE_OFS_BITS)

`define DATA_BITS 64

// command queue between core and memory
`define CMDQ_DEPTH 16

// memory transaction numbers, 0 reserved for none
`define XACT_NUM_BITS 4

// accept to data return
`define MEM_LATENCY 6

// memory size in words
`define MEM_WORD_BITS 10

`endif

// File: design/dcache_pkg.sv
// data cache shared types
`default_nettype none
`include "dcache_defs.svh"

package dcache_pkg;

  // memory bus commands
  typedef enum logic [1:0] {
    MEM_NONE  = 2'd0,
    MEM_LOAD  = 2'd1,
    MEM_STORE = 2'd2
  } mem_cmd_e;

  typedef struct packed {
    logic [6:0] pr;   // physical dest
    logic [4:0] ar;   // architectural dest
  } dest_t;

  typedef struct packed {
    logic                  load;
    logic                  store;
    logic [`ADDR_BITS-1:0] addr;
    logic [`DATA_BITS-1:0] st_data;
    dest_t                 dest;
  } lsq_req_t;

  typedef struct packed {
    logic                  valid;
    dest_t                 dest;
    logic [`DATA_BITS-1:0] data;
  } cdb_t;

  typedef struct packed {
    mem_cmd_e              cmd;
    logic [`ADDR_BITS-1:0] addr;
    logic [`DATA_BITS-1:0] data;
  } mem_req_t;

  typedef struct packed {
    logic [`XACT_NUM_BITS-1:0] response;   // number granted now, 0 if refused
    logic [`XACT_NUM_BITS-1:0] tag;        // number whose data is back
    logic [`DATA_BITS-1:0]     data;
  } mem_rsp_t;

  typedef struct packed {
    logic                        en;
    logic [`DCACHE_IDX_BITS-1:0] idx;
    logic [`DCACHE_TAG_BITS-1:0] tag;
    logic [`DATA_BITS-1:0]       data;
  } array_wr_t;

  typedef struct packed {
    logic                  hit;
    logic [`DATA_BITS-1:0] data;
  } array_rd_t;

endpackage

`default_nettype wire

// File: design/dcache_top.sv
// data cache top
`default_nettype none
`include "dcache_defs.svh"

module dcache_top (
  input  logic                 clock,
  input  logic                 reset,
  input  dcache_pkg::lsq_req_t lsq_req,
  output logic                 req_ready,
  output dcache_pkg::cdb_t     cdb,
  input  logic                 halt,
  output logic                 halted
);

  logic [`ADDR_BITS-1:0] lookup_addr;
  dcache_pkg::array_rd_t lookup;
  dcache_pkg::array_wr_t store_wr;
  dcache_pkg::array_wr_t fill_wr;
  dcache_pkg::mem_req_t  mem_req;
  dcache_pkg::mem_rsp_t  mem_rsp;

  dcache_ctrl u_ctrl (
    .clock       (clock),
    .reset       (reset),
    .lsq_req     (lsq_req),
    .req_ready   (req_ready),
    .cdb         (cdb),
    .halt        (halt),
    .halted      (halted),
    .lookup_addr (lookup_addr),
    .lookup      (lookup),
    .store_wr    (store_wr),
    .fill_wr     (fill_wr),
    .mem_req     (mem_req),
    .mem_rsp     (mem_rsp)
  );

  dcache_array u_array (
    .clock       (clock),
    .reset       (reset),
    .lookup_addr (lookup_addr),
    .lookup      (lookup),
    .store_wr    (store_wr),
    .fill_wr     (fill_wr)
  );

  // single requester, memory hangs straight off the queue head
  tagged_mem u_mem (
    .clock   (clock),
    .reset   (reset),
    .mem_req (mem_req),
    .mem_rsp (mem_rsp)
  );

endmodule

`default_nettype wire

// File: design/tagged_mem.sv
// tagged main memory
`default_nettype none
`include "dcache_defs.svh"

module tagged_mem (
  input  logic                 clock,
  input  logic                 reset,
  input  dcache_pkg::mem_req_t mem_req,
  output dcache_pkg::mem_rsp_t mem_rsp
);

  localparam int WORDS = 1 << `MEM_WORD_BITS;
  localparam int NUMS = 1 << `XACT_NUM_BITS;
  localparam int LAT = `MEM_LATENCY;
  localparam logic [`XACT_NUM_BITS-1:0] LAST_NUM = `XACT_NUM_BITS'(NUMS - 1);

  logic [`DATA_BITS-1:0] mem [WORDS];

  logic [`XACT_NUM_BITS-1:0] next_num;
  logic [NUMS-1:0]           in_flight;   // bit 0 never set
  logic [`XACT_NUM_BITS-1:0] pipe_num  [LAT];
  logic [`DATA_BITS-1:0]     pipe_data [LAT];

  logic                      grant;
  logic                      load_grant;
  logic [`MEM_WORD_BITS-1:0] word;

  // each word holds its own index in both halves
  initial
  begin
    for (int i = 0; i < WORDS; i++)
      mem[i] = {2{32'(i)}};
  end

  assign word       = mem_req.addr[`DCACHE_OFS_BITS +: `MEM_WORD_BITS];
  assign grant      = (mem_req.cmd != dcache_pkg::MEM_NONE) && !in_flight[next_num];
  assign load_grant = grant && (mem_req.cmd == dcache_pkg::MEM_LOAD);

  assign mem_rsp.response = grant ? next_num : '0;
  assign mem_rsp.tag      = pipe_num[LAT-1];
  assign mem_rsp.data     = pipe_data[LAT-1];

  always_ff @(posedge clock)
  begin
    if (reset)
    begin
      next_num  <= `XACT_NUM_BITS'(1);
      in_flight <= '0;
      for (int i = 0; i < LAT; i++)
        pipe_num[i] <= '0;
    end
    else
    begin
      if (grant)
        next_num <= (next_num == LAST_NUM) ? `XACT_NUM_BITS'(1) : next_num + 1'b1;
      if (pipe_num[LAT-1] != '0)
        in_flight[pipe_num[LAT-1]] <= 1'b0;   // number free again
      if (load_grant)
        in_flight[next_num] <= 1'b1;
      pipe_num[0] <= load_grant ? next_num : '0;
      for (int i = 1; i < LAT; i++)
        pipe_num[i] <= pipe_num[i-1];
    end
  end

  // read and write both happen at accept
  always_ff @(posedge clock)
  begin
    if (grant && mem_req.cmd == dcache_pkg::MEM_STORE)
      mem[word] <= mem_req.data;
    pipe_data[0] <= mem[word];
    for (int i = 1; i < LAT; i++)
      pipe_data[i] <= pipe_data[i-1];
  end

endmodule

`default_nettype wire

// File: run.sh
#!/bin/sh
# build and run the data cache testbench with Verilator
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal \
  -f vlog.f --top-module dcache_tb -o dcache_sim &&
./obj_dir/dcache_sim || exit 1

// File: sim/dcache_tb.sv
// data cache testbench
`default_nettype none
`include "dcache_defs.svh"

module dcache_tb;

  localparam int N_RANDOM = 400;
  localparam int N_TOTAL = N_RANDOM + 4 + 8 + 24 + 4;   // random plus directed requests
  localparam int WORDS = 1 << `MEM_WORD_BITS;
  localparam logic [6:0] STORE_PR = 7'h7f;   // pr carried by stores only
  localparam int MODE_ANY = 0;
  localparam int MODE_MISS = 1;
  localparam int MODE_HIT = 2;

  logic                 clock;
  logic                 reset;
  logic                 halt;
  logic                 req_ready;
  logic                 halted;
  dcache_pkg::lsq_req_t lsq_req;
  dcache_pkg::cdb_t     cdb;

  // reference model
  logic [`DATA_BITS-1:0] ref_mem  [WORDS];
  logic [`DATA_BITS-1:0] exp_data [128];
  logic [4:0]            exp_ar   [128];
  logic [127:0]          pending;
  int                    n_outstanding;

  int         expect_mode;
  int         held_cycles;
  int         drained_wait;
  logic       halt_driven;
  logic       halted_seen;
  logic [6:0] next_pr;
  integer     seed;

  dcache_top u_dcache_top (
    .clock     (clock),
    .reset     (reset),
    .lsq_req   (lsq_req),
    .req_ready (req_ready),
    .cdb       (cdb),
    .halt      (halt),
    .halted    (halted)
  );

  task automatic stop_with_failure(input string line);
    $display("%s", line);
    $display("Test failed");
    $fatal(1);
  endtask

  // 24 addresses over indices 0..7 with three tags per index
  function automatic int test_word(input int k);
    return (k % 8) + 32 * (k / 8);
  endfunction

  function automatic logic [6:0] alloc_pr();
    logic [6:0] pr;
    pr = next_pr;
    while (pending[pr] || pr == STORE_PR)
      pr = pr + 7'd1;
    next_pr = pr + 7'd1;
    return pr;
  endfunction

  // drive one request and hold it until taken
  task automatic send(input logic is_store, input int word, input int mode);
    logic [6:0] pr;
    pr = is_store ? STORE_PR : alloc_pr();
    expect_mode     = mode;
    lsq_req.load    = !is_store;
    lsq_req.store   = is_store;
    lsq_req.addr    = `ADDR_BITS'(word) << `DCACHE_OFS_BITS;
    lsq_req.st_data = {$random(seed), $random(seed)};
    lsq_req.dest.pr = pr;
    lsq_req.dest.ar = 5'($random(seed));
    @(negedge clock);
    while (!req_ready)
    begin
      held_cycles++;
      @(negedge clock);
    end
    @(posedge clock);
    #2;
    lsq_req.load  = 1'b0;
    lsq_req.store = 1'b0;
    expect_mode   = MODE_ANY;
  endtask

  task automatic wait_drained(input int limit);
    int n;
    n = 0;
    while (n_outstanding != 0 && n < limit)
    begin
      @(posedge clock);
      #2;
      n++;
    end
    assert (n_outstanding == 0)
      else stop_with_failure("outstanding loads never completed on the result bus");
  endtask

  initial
  begin
    clock = 1'b0;
    forever #10 clock = ~clock;
  end

  initial
  begin
    #(N_TOTAL * (`MEM_LATENCY + 20) * 20);
    stop_with_failure("timeout: the run did not finish in the allowed time");
  end

  // monitor and reference model, sampled mid-cycle
  always @(negedge clock)
  begin
    logic [6:0]                pr;
    logic [`MEM_WORD_BITS-1:0] word;
    if (reset)
    begin
      assert (!cdb.valid && !halted)
        else stop_with_failure($sformatf("error at %0t: cdb or halted active in reset", $time));
    end
    else
    begin
      word = lsq_req.addr[`DCACHE_OFS_BITS +: `MEM_WORD_BITS];
      if (req_ready && lsq_req.store)
        ref_mem[word] = lsq_req.st_data;
      if (req_ready && lsq_req.load)
      begin
        pr = lsq_req.dest.pr;
        pending[pr]  = 1'b1;
        exp_data[pr] = ref_mem[word];
        exp_ar[pr]   = lsq_req.dest.ar;
        n_outstanding++;
        if (expect_mode == MODE_HIT)
        begin
          assert (cdb.valid && cdb.dest.pr == pr)
            else stop_with_failure($sformatf("error at %0t: repeat load to word %0d missed",
                                             $time, word));
        end
        if (expect_mode == MODE_MISS)
        begin
          assert (!(cdb.valid && cdb.dest.pr == pr))
            else stop_with_failure($sformatf("error at %0t: cold load to word %0d hit",
                                             $time, word));
        end
      end
      if (cdb.valid)
      begin
        pr = cdb.dest.pr;
        assert (pending[pr])
          else stop_with_failure($sformatf("error at %0t: cdb for pr %0d with no load pending",
                                           $time, pr));
        assert (cdb.dest.ar == exp_ar[pr] && cdb.data == exp_data[pr])
          else stop_with_failure($sformatf("error at %0t: pr %0d got %h ar %0d, expected %h ar %0d",
                                           $time, pr, cdb.data, cdb.dest.ar, exp_data[pr],
                                           exp_ar[pr]));
        pending[pr] = 1'b0;
        n_outstanding--;
      end
      if (halted)
        halted_seen = 1'b1;
      assert (!halted || (halt_driven && n_outstanding == 0))
        else stop_with_failure($sformatf("error at %0t: halted high with work pending", $time));
      assert (!halted_seen || halted)
        else stop_with_failure($sformatf("error at %0t: halted dropped", $time));
      if (halt_driven && n_outstanding == 0 && !halted)
        drained_wait++;
      assert (drained_wait <= 2)
        else stop_with_failure($sformatf("error at %0t: halted late after drain", $time));
    end
  end

  initial
  begin
    int r;
    seed          = 32'h578;
    reset         = 1'b1;
    halt          = 1'b0;
    lsq_req       = '0;
    pending       = '0;
    n_outstanding = 0;
    expect_mode   = MODE_ANY;
    held_cycles   = 0;
    drained_wait  = 0;
    halt_driven   = 1'b0;
    halted_seen   = 1'b0;
    next_pr       = '0;
    for (int i = 0; i < WORDS; i++)
      ref_mem[i] = {2{32'(i)}};   // memory starts with word index in both halves
    repeat (10) @(posedge clock);
    #2;
    reset = 1'b0;

    // cold miss then a hit on the filled line
    for (int k = 0; k < 2; k++)
    begin
      send(1'b0, test_word(k), MODE_MISS);
      wait_drained(200);
      send(1'b0, test_word(k), MODE_HIT);
      wait_drained(200);
    end

    // fills land in the middle of a store burst
    for (int k = 8; k < 16; k++)
      send(1'b0, test_word(k), MODE_MISS);
    held_cycles = 0;
    for (int n = 0; n < 24; n++)
    begin
      r = $random(seed);
      send(1'b1, test_word($unsigned(r) % 24), MODE_ANY);
    end
    assert (held_cycles > 0)
      else stop_with_failure("req_ready never dropped during the store burst");
    wait_drained(300);

    for (int n = 0; n < N_RANDOM; n++)
    begin
      r = $random(seed);
      if (r[4:2] == 3'd0)
      begin
        @(posedge clock);
        #2;
      end
      send(r[1:0] == 2'd0, test_word(($unsigned(r) >> 8) % 24), MODE_ANY);
    end
    wait_drained(500);

    // halt with cold misses in flight
    for (int k = 0; k < 4; k++)
      send(1'b0, 200 + k, MODE_MISS);
    halt        = 1'b1;
    halt_driven = 1'b1;
    assert (n_outstanding != 0)
      else stop_with_failure("halt phase loads finished before halt was driven");
    wait_drained(200);
    repeat (6) @(negedge clock);

    if (n_outstanding != 0 || !halted)
      stop_with_failure("halted is not high after all traffic drained");
    else
    begin
      $display("Test completed successfully");
      $finish;
    end
  end

endmodule

`default_nettype wire

// File: vlog.f
+incdir+design
design/dcache_pkg.sv
design/dcache_array.sv
design/dcache_ctrl.sv
design/tagged_mem.sv
design/dcache_top.sv
sim/dcache_tb.sv
